/* Makefile */
VERILATOR ?= verilator
TOP       ?= bubble_timing_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/bubble_timing_tb.sv */
module bubble_timing_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // pins {n_en, n_bss, n_bsen, n_repen, n_booten, n_swapen}
    // kind 1 page 2 boot 3 stop
    typedef struct packed {
        logic [5:0]                 pins;
        int                         cycles;
        bubble_timing_pkg::access_t exp;
        logic [1:0]                 kind;
    } step_t;

    localparam int NSTEPS = 12;
    localparam step_t STEPS [NSTEPS] = '{
        '{6'b011111, 0,   bubble_timing_pkg::RST,  2'd0},  // reset pattern
        '{6'b001111, 0,   bubble_timing_pkg::STBY, 2'd0},  // shift start
        '{6'b010101, 110, bubble_timing_pkg::BOOT, 2'd2},  // bootloop shift
        '{6'b011101, 0,   bubble_timing_pkg::RST,  2'd3},  // reset on bootloop side
        '{6'b001111, 0,   bubble_timing_pkg::STBY, 2'd0},
        '{6'b010111, 3,   bubble_timing_pkg::IDLE, 2'd0},  // page shift
        '{6'b010011, 690, bubble_timing_pkg::USER, 2'd1},  // replicate pulse
        '{6'b011111, 0,   bubble_timing_pkg::RST,  2'd3},
        '{6'b001111, 0,   bubble_timing_pkg::STBY, 2'd0},
        '{6'b010111, 3,   bubble_timing_pkg::IDLE, 2'd0},
        '{6'b010110, 3,   bubble_timing_pkg::SWAP, 2'd0},  // swap pulse
        '{6'b100000, 0,   bubble_timing_pkg::RST,  2'd3}   // module disabled
    };

    logic MCLK, rst_n;
    logic n_en, n_bss, n_bsen, n_repen, n_booten, n_swapen;
    logic clkout, n_binclken, n_boutclken;
    bubble_timing_pkg::access_t   acc_type;
    bubble_timing_pkg::bout_num_t bout_cycle_num;
    bubble_timing_pkg::abs_page_t abs_page;

    int err [1:6];
    bit mon_on;
    int cyc, last_bin, last_bout, last_page_t;
    logic bl1, bl2;  // read enable low one and two samples back
    logic [11:0] prev_abs;

    tb_clock clk_gen (.MCLK(MCLK), .rst_n(rst_n));

    bubble_timing_top uut (
        .MCLK(MCLK), .rst_n(rst_n), .n_en(n_en), .n_bss(n_bss), .n_bsen(n_bsen),
        .n_repen(n_repen), .n_booten(n_booten), .n_swapen(n_swapen),
        .clkout(clkout), .acc_type(acc_type), .bout_cycle_num(bout_cycle_num),
        .n_binclken(n_binclken), .n_boutclken(n_boutclken), .abs_page(abs_page)
    );

    //////////////////////////////
    // field timing monitor
    //////////////////////////////

    always @(negedge MCLK)
    begin
        if (mon_on)
        begin
            cyc = cyc + 1;
            if (!n_boutclken && bl1)
            begin
                last_bin = -1;  // field parked so gaps restart
                last_bout = -1;
                last_page_t = -1;
            end
            else
            begin
                if (!n_binclken)
                begin
                    if (last_bin >= 0)
                        assert (cyc - last_bin == 480) else begin
                            $display("[FAIL] %0t: write enable gap %0d", $time, cyc - last_bin);
                            err[3]++;
                        end
                    last_bin = cyc;
                end
                if (n_boutclken && bl1 && !bl2)  // single low sample one cycle ago
                begin
                    if (last_bout >= 0)
                        assert (cyc - 1 - last_bout == 480) else begin
                            $display("[FAIL] %0t: read enable gap %0d", $time,
                                     cyc - 1 - last_bout);
                            err[3]++;
                        end
                    last_bout = cyc - 1;
                end
            end
            if (abs_page != prev_abs)
            begin
                assert (int'(abs_page) == (int'(prev_abs) + 1) % 2053) else begin
                    $display("[FAIL] %0t: abs_page %0d after %0d", $time, abs_page, prev_abs);
                    err[3]++;
                end
                if (last_page_t >= 0)
                    assert (cyc - last_page_t == 480) else begin
                        $display("[FAIL] %0t: abs_page step after %0d MCLK", $time,
                                 cyc - last_page_t);
                        err[3]++;
                    end
                last_page_t = cyc;
                prev_abs = abs_page;
            end
            bl2 = bl1;
            bl1 = !n_boutclken;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic wait_access(input bubble_timing_pkg::access_t exp, input int step);
        int t;
        t = 0;
        while (acc_type != exp && t < 8)  // sync chain plus sample wait
        begin
            @(negedge MCLK);
            t++;
        end
        assert (acc_type == exp) else begin
            $display("[FAIL] %0t: step %0d acc_type %s, expected %s", $time, step,
                     acc_type.name(), exp.name());
            err[2]++;
        end
    endtask

    // counts +Y events by abs_page steps and checks the bit numbering
    task automatic run_cycles(input int cycles, input logic [1:0] kind);
        int k;
        int t;
        int exp_num;
        logic [11:0] seen_abs;
        bubble_timing_pkg::bout_num_t prev;
        k = 0;
        t = 0;
        prev = '1;
        seen_abs = abs_page;
        while (k < cycles && t < (cycles + 2) * 480)
        begin
            @(negedge MCLK);
            t++;
            if (abs_page != seen_abs)
            begin
                seen_abs = abs_page;
                k++;
                if (kind == 2'd1)
                begin
                    exp_num = (k <= 98) ? 8191 : ((k - 99 > 583) ? 583 : k - 99);
                    assert (int'(bout_cycle_num) == exp_num) else begin
                        $display("[FAIL] %0t: page bit %0d, expected %0d", $time,
                                 bout_cycle_num, exp_num);
                        err[4]++;
                    end
                end
                else if (kind == 2'd2)
                begin
                    if (k <= 98)
                        exp_num = 8191;
                    else if (k == 99)
                        // bootloop counter steps with abs_page over twice the loop
                        exp_num = (int'(bout_cycle_num) >= 2053) ?
                                  int'(abs_page) + 2053 : int'(abs_page);
                    else
                        exp_num = (int'(prev) + 1) % 4106;
                    assert (int'(bout_cycle_num) == exp_num) else begin
                        $display("[FAIL] %0t: bootloop bit %0d at cycle %0d", $time,
                                 bout_cycle_num, k);
                        err[5]++;
                    end
                end
                prev = bout_cycle_num;
            end
        end
        if (k < cycles)
        begin
            $display("timeout: only %0d of %0d bubble cycles seen", k, cycles);
            err[3]++;
        end
    endtask

    task automatic wait_stop();
        int t;
        logic was_low;
        t = 0;
        was_low = 1'b0;
        while (!(was_low && !n_boutclken) && t < 1200)
        begin
            was_low = !n_boutclken;
            @(negedge MCLK);
            t++;
        end
        if (t >= 1200)
        begin
            $display("timeout: field did not stop");
            err[6]++;
        end
        assert (bout_cycle_num == '1) else begin
            $display("[FAIL] %0t: bout_cycle_num %0d after stop", $time, bout_cycle_num);
            err[6]++;
        end
    endtask

    task automatic report(input int n, input string name);
        $display("test %0d %s: %s", n, name, (err[n] == 0) ? "passed" : "failed");
    endtask

    //////////////////////////////
    // sequence
    //////////////////////////////

    initial
    begin
        int seed;
        int gap;
        int t;
        int edges;
        int last_edge;
        int total;
        int failed;
        logic last_clk;
        step_t s;
        seed = 32'hd713;
        {n_en, n_bss, n_bsen, n_repen, n_booten, n_swapen} = 6'b011111;
        for (int i = 1; i <= 6; i++)
            err[i] = 0;
        mon_on = 1'b0;
        cyc = 0;
        last_bin = -1;
        last_bout = -1;
        last_page_t = -1;
        bl1 = 1'b0;
        bl2 = 1'b0;
        t = 0;
        while (!rst_n && t < 20)
        begin
            @(posedge MCLK);
            t++;
        end
        if (!rst_n)
        begin
            $display("timeout: reset never released");
            err[1]++;
        end
        @(negedge MCLK);
        assert (clkout && acc_type == bubble_timing_pkg::RST && n_binclken && !n_boutclken &&
                bout_cycle_num == '1 && abs_page == 12'd1951) else begin
            $display("[FAIL] %0t: reset values wrong", $time);
            err[1]++;
        end
        prev_abs = abs_page;

        // controller clock edge to edge
        last_clk = clkout;
        last_edge = -1;
        edges = 0;
        t = 0;
        while (edges < 4 && t < 40)
        begin
            @(negedge MCLK);
            t++;
            if (clkout != last_clk)
            begin
                if (last_edge >= 0)
                    assert (t - last_edge == 6) else begin
                        $display("[FAIL] %0t: clkout half period %0d", $time, t - last_edge);
                        err[1]++;
                    end
                last_edge = t;
                edges++;
                last_clk = clkout;
            end
        end
        if (edges < 4)
        begin
            $display("timeout: clkout stopped toggling");
            err[1]++;
        end
        report(1, "reset and controller clock");
        mon_on = 1'b1;

        for (int i = 0; i < NSTEPS; i++)
        begin
            s = STEPS[i];
            gap = int'({$random(seed)} % 16);  // idle gap between steps
            repeat (gap) @(negedge MCLK);
            {n_en, n_bss, n_bsen, n_repen, n_booten, n_swapen} <= s.pins;
            wait_access(s.exp, i);
            if (s.kind == 2'd3)
                wait_stop();
            else
                run_cycles(s.cycles, s.kind);
            if (i == 2)
                report(5, "bootloop numbering");
            if (i == 6)
                report(4, "page numbering");
        end
        report(2, "access type sequence");
        report(3, "field timing");
        report(6, "enable override");

        total = 0;
        failed = 0;
        for (int i = 1; i <= 6; i++)
        begin
            total += err[i];
            if (err[i] != 0)
                failed++;
        end
        $display("6 tests, %0d failed, %0d errors", failed, total);
        if (total == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic MCLK,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        MCLK = 1'b0;
        forever
        begin
            #50 MCLK = ~MCLK;  // 100 ns period
        end
    end

    // reset low for 4 rising edges, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge MCLK);
        @(negedge MCLK);
        rst_n = 1'b1;
    end

endmodule

/* source/access_state.sv */
module access_state (
    input  logic MCLK,
    input  logic rst_n,
    bmc_ctrl_if.dst ctrl,
    output bubble_timing_pkg::access_t acc_type
);

    // {bss, booten, bsen, repen, swapen}, all active low
    logic [4:0] pattern;

    assign pattern = {ctrl.bss, ctrl.booten, ctrl.bsen, ctrl.repen, ctrl.swapen};

    //////////////////////////////
    // access type FSM
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            acc_type <= bubble_timing_pkg::RST;
        end
        else
        begin
            case (pattern)
                // reset patterns, bootloop side and user side
                5'b10111, 5'b11111:
                begin
                    if (acc_type != bubble_timing_pkg::STBY)
                    begin
                        acc_type <= bubble_timing_pkg::RST;  // standby survives
                    end
                end

                // shift start pulse
                5'b00111, 5'b01111:
                begin
                    if (acc_type == bubble_timing_pkg::RST)
                    begin
                        acc_type <= bubble_timing_pkg::STBY;
                    end
                end

                // bootloop shifting
                5'b10011:
                begin
                    if (acc_type == bubble_timing_pkg::STBY ||
                        acc_type == bubble_timing_pkg::RST ||
                        acc_type == bubble_timing_pkg::BOOT)
                    begin
                        acc_type <= bubble_timing_pkg::BOOT;
                    end
                end

                // page seek, field on with no transfer yet
                5'b11011:
                begin
                    if (acc_type == bubble_timing_pkg::STBY ||
                        acc_type == bubble_timing_pkg::RST)
                    begin
                        acc_type <= bubble_timing_pkg::IDLE;
                    end
                end

                5'b11001:  // replicator pulse
                begin
                    if (acc_type == bubble_timing_pkg::IDLE)
                    begin
                        acc_type <= bubble_timing_pkg::USER;  // held until reset pattern
                    end
                end

                5'b11010:  // swap pulse
                begin
                    if (acc_type == bubble_timing_pkg::IDLE)
                    begin
                        acc_type <= bubble_timing_pkg::SWAP;
                    end
                end

                default:
                begin
                    acc_type <= acc_type;
                end
            endcase
        end
    end

endmodule

/* source/bubble_timing_pkg.sv */
package bubble_timing_pkg;

    //////////////////////////////
    // access types
    //////////////////////////////

    // bit 2 field rotating, bit 1 data transfer
    typedef enum logic [2:0] {
        RST  = 3'b000,  // idle after reset or bootloop end
        STBY = 3'b001,  // shift start seen
        BOOT = 3'b110,  // bootloop read
        USER = 3'b111,  // page read, replicator active
        IDLE = 3'b100,  // page seek, field running
        SWAP = 3'b101   // page write through swap gate
    } access_t;

    typedef logic [9:0]  field_phase_t;  // 0 stopped, 89..568 running
    typedef logic [11:0] abs_page_t;     // minor loop position
    typedef logic [12:0] bout_num_t;     // all ones = no valid bit

    //////////////////////////////
    // field positions in MCLK
    //////////////////////////////

    localparam field_phase_t PHASE_MINUS_X = 10'd208;  // stop point
    localparam field_phase_t PHASE_MINUS_Y = 10'd328;  // detector latch
    localparam field_phase_t PHASE_PLUS_Y  = 10'd568;  // end of bubble cycle
    localparam field_phase_t PHASE_WRAP    = 10'd89;   // first count of next cycle
    localparam field_phase_t BIN_START     = 10'd88;   // first write sample
    localparam field_phase_t BOUT_ADVANCE  = 10'd2;    // output strobe launched early

    // counting limits
    localparam abs_page_t   LOOP_POSITIONS     = 12'd2053;  // bubbles per minor loop
    localparam bout_num_t   BOOTLOOP_BITS      = 13'd4106;  // two bootloops interleaved
    localparam logic [9:0]  PAGE_BITS          = 10'd584;
    localparam logic [6:0]  PROPAGATION_CYCLES = 7'd98;     // replicator to detector

endpackage

/* source/bubble_timing_top.sv */
interface bmc_ctrl_if;
    logic bss;     // shift start
    logic bsen;    // shift enable
    logic repen;   // replicator enable
    logic booten;  // bootloop enable
    logic swapen;  // swap gate enable

    modport src (output bss, bsen, repen, booten, swapen);
    modport dst (input  bss, bsen, repen, booten, swapen);
endinterface

module bubble_timing_top #(
    parameter bubble_timing_pkg::abs_page_t INITIAL_ABS_PAGE = 12'd1951,
    parameter int                           SYNC_STAGES      = 3
) (
    input  logic                         MCLK,
    input  logic                         rst_n,
    input  logic                         n_en,
    input  logic                         n_bss,
    input  logic                         n_bsen,
    input  logic                         n_repen,
    input  logic                         n_booten,
    input  logic                         n_swapen,
    output logic                         clkout,
    output bubble_timing_pkg::access_t   acc_type,
    output bubble_timing_pkg::bout_num_t bout_cycle_num,
    output logic                         n_binclken,
    output logic                         n_boutclken,
    output bubble_timing_pkg::abs_page_t abs_page
);

    logic                           sample_tick;
    bubble_timing_pkg::field_phase_t phase;

    bmc_ctrl_if ctrl_bus ();

    phase_divider u_divider (
        .MCLK(MCLK), .rst_n(rst_n), .clkout(clkout), .sample_tick(sample_tick)
    );

    control_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
        .MCLK(MCLK), .rst_n(rst_n), .n_en(n_en),
        .n_bss(n_bss), .n_bsen(n_bsen), .n_repen(n_repen),
        .n_booten(n_booten), .n_swapen(n_swapen),
        .sample_tick(sample_tick), .ctrl(ctrl_bus.src)
    );

    access_state u_access (
        .MCLK(MCLK), .rst_n(rst_n), .ctrl(ctrl_bus.dst), .acc_type(acc_type)
    );

    field_rotation #(.INITIAL_ABS_PAGE(INITIAL_ABS_PAGE)) u_field (
        .MCLK(MCLK), .rst_n(rst_n), .acc_type(acc_type), .phase(phase),
        .abs_page(abs_page), .n_binclken(n_binclken), .n_boutclken(n_boutclken)
    );

    cycle_counter #(.INITIAL_ABS_PAGE(INITIAL_ABS_PAGE)) u_cycle (
        .MCLK(MCLK), .rst_n(rst_n), .acc_type(acc_type), .phase(phase),
        .bout_cycle_num(bout_cycle_num)
    );

endmodule

/* source/control_sync.sv */
module control_sync #(
    parameter int SYNC_STAGES = 3
) (
    input  logic MCLK,
    input  logic rst_n,
    input  logic n_en,
    input  logic n_bss,
    input  logic n_bsen,
    input  logic n_repen,
    input  logic n_booten,
    input  logic n_swapen,
    input  logic sample_tick,
    bmc_ctrl_if.src ctrl
);

    // bit order {swapen, bss, bsen, repen, booten}
    localparam logic [4:0] IDLE_PATTERN = 5'b11110;

    logic [4:0] gated;
    logic [4:0] chain [SYNC_STAGES];

    //////////////////////////////
    // input gating
    //////////////////////////////

    assign gated[4] = n_en | n_swapen;
    assign gated[3] = n_en | n_bss;
    assign gated[2] = n_en | n_bsen;
    assign gated[1] = n_en | n_repen | ~n_booten;  // no replicate while on bootloop
    assign gated[0] = ~n_en & n_booten;             // module off reads as bootloop idle

    // falling edge buffer chain
    always_ff @(negedge MCLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                chain[i] <= IDLE_PATTERN;
            end
        end
        else
        begin
            chain[0] <= gated;
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                chain[i] <= chain[i-1];  // shift
            end
        end
    end

    //////////////////////////////
    // strobe-timed sampling
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            {ctrl.swapen, ctrl.bss, ctrl.bsen, ctrl.repen, ctrl.booten} <= IDLE_PATTERN;
        end
        else if (sample_tick)
        begin
            {ctrl.swapen, ctrl.bss, ctrl.bsen, ctrl.repen, ctrl.booten} <=
                chain[SYNC_STAGES-1];  // levels hold between ticks
        end
    end

endmodule

/* source/cycle_counter.sv */
module cycle_counter #(
    parameter bubble_timing_pkg::abs_page_t INITIAL_ABS_PAGE = 12'd1951
) (
    input  logic                            MCLK,
    input  logic                            rst_n,
    input  bubble_timing_pkg::access_t      acc_type,
    input  bubble_timing_pkg::field_phase_t phase,
    output bubble_timing_pkg::bout_num_t    bout_cycle_num
);

    logic [6:0]                   delay_cnt;  // all ones = not started
    logic [9:0]                   page_cnt;   // all ones = before bit 0
    bubble_timing_pkg::bout_num_t boot_cnt;   // free running over both bootloops
    bubble_timing_pkg::bout_num_t boot_next;
    logic                         delay_done;
    logic                         page_full;
    logic                         plus_y;

    assign plus_y     = (phase == bubble_timing_pkg::PHASE_PLUS_Y);
    assign delay_done = (delay_cnt == bubble_timing_pkg::PROPAGATION_CYCLES - 7'd1);
    assign page_full  = (page_cnt == bubble_timing_pkg::PAGE_BITS - 10'd1);
    assign boot_next  = (boot_cnt == bubble_timing_pkg::BOOTLOOP_BITS - 13'd1) ?
                        13'd0 : boot_cnt + 13'd1;

    //////////////////////////////
    // bootloop counter
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            boot_cnt <= {1'b0, INITIAL_ABS_PAGE};
        end
        else if (plus_y)
        begin
            boot_cnt <= boot_next;  // advances in every mode
        end
    end

    //////////////////////////////
    // delay, page and output
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            delay_cnt      <= '1;
            page_cnt       <= '1;
            bout_cycle_num <= '1;
        end
        else if (phase == '0)
        begin
            if (acc_type == bubble_timing_pkg::RST)
            begin
                delay_cnt      <= '1;  // field stopped, forget the page
                page_cnt       <= '1;
                bout_cycle_num <= '1;
            end
        end
        else if (plus_y)
        begin
            if (!acc_type[1])
            begin
                delay_cnt      <= '1;  // IDLE or SWAP moves no data out
                page_cnt       <= '1;
                bout_cycle_num <= '1;
            end
            else if (!delay_done)
            begin
                delay_cnt      <= delay_cnt + 7'd1;  // all ones wraps to 0
                page_cnt       <= '1;
                bout_cycle_num <= '1;  // line still empty
            end
            else if (!acc_type[0])
            begin
                page_cnt       <= '1;
                bout_cycle_num <= boot_next;  // BOOT tracks bootloop position
            end
            else if (!page_full)
            begin
                page_cnt       <= page_cnt + 10'd1;
                bout_cycle_num <= {3'b000, page_cnt + 10'd1};
            end
            // last page bit holds
        end
    end

endmodule

/* source/field_rotation.sv */
module field_rotation #(
    parameter bubble_timing_pkg::abs_page_t INITIAL_ABS_PAGE = 12'd1951
) (
    input  logic                            MCLK,
    input  logic                            rst_n,
    input  bubble_timing_pkg::access_t      acc_type,
    output bubble_timing_pkg::field_phase_t phase,
    output bubble_timing_pkg::abs_page_t    abs_page,
    output logic                            n_binclken,  // write sample enable
    output logic                            n_boutclken  // read launch enable
);

    //  field positions in one cycle
    //          +Y 568
    //  -X 208          +X 448
    //          -Y 328

    //////////////////////////////
    // rotation phase
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            phase <= '0;
        end
        else if (phase == '0)
        begin
            phase <= acc_type[2] ? 10'd1 : 10'd0;  // start on rotate request
        end
        else if (phase == bubble_timing_pkg::PHASE_MINUS_X && !acc_type[2])
        begin
            phase <= '0;  // field parks at -X
        end
        else if (phase == bubble_timing_pkg::PHASE_PLUS_Y)
        begin
            phase <= bubble_timing_pkg::PHASE_WRAP;  // 480 MCLK per cycle
        end
        else
        begin
            phase <= phase + 10'd1;
        end
    end

    //////////////////////////////
    // absolute loop position
    //////////////////////////////

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            abs_page <= INITIAL_ABS_PAGE;
        end
        else if (phase == bubble_timing_pkg::PHASE_PLUS_Y)
        begin
            if (abs_page == bubble_timing_pkg::LOOP_POSITIONS - 12'd1)
            begin
                abs_page <= '0;  // replicator at position 0
            end
            else
            begin
                abs_page <= abs_page + 12'd1;
            end
        end
    end

    // write enable at cycle start and every +Y
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            n_binclken <= 1'b1;
        end
        else
        begin
            n_binclken <= !(phase == bubble_timing_pkg::BIN_START ||
                            phase == bubble_timing_pkg::PHASE_PLUS_Y);
        end
    end

    // read enable just ahead of -Y, low while stopped
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            n_boutclken <= 1'b0;
        end
        else
        begin
            n_boutclken <= !(phase == '0 ||
                phase == bubble_timing_pkg::PHASE_MINUS_Y - bubble_timing_pkg::BOUT_ADVANCE);
        end
    end

endmodule

/* source/phase_divider.sv */
module phase_divider (
    input  logic MCLK,
    input  logic rst_n,
    output logic clkout,      // 4 MHz controller clock
    output logic sample_tick  // one per 12 MHz period
);

    //////////////////////////////
    // 48 MHz / 12 counter
    //////////////////////////////

    logic [3:0] count;

    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            count <= 4'd0;
        end
        else if (count == 4'd11)
        begin
            count <= 4'd0;  // wrap every 250 ns
        end
        else
        begin
            count <= count + 4'd1;
        end
    end

    // high 6, low 6
    always_ff @(posedge MCLK)
    begin
        if (!rst_n)
        begin
            clkout <= 1'b1;
        end
        else if (count == 4'd5)
        begin
            clkout <= 1'b1;  // rising edge
        end
        else if (count == 4'd11)
        begin
            clkout <= 1'b0;  // controller launches on this edge
        end
    end

    // sample points sit mid-way through each 12 MHz period
    assign sample_tick = (count == 4'd3) || (count == 4'd7) || (count == 4'd11);

endmodule

/* sources.f */
source/bubble_timing_pkg.sv
source/phase_divider.sv
source/control_sync.sv
source/access_state.sv
source/field_rotation.sv
source/cycle_counter.sv
source/bubble_timing_top.sv
bench/tb_clock.sv
bench/bubble_timing_tb.sv
